// ==== hw/row_buffer_pkg.sv ====
package row_buffer_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Pixel format
    ////////////////////////////////////////////////////////////////////////////

    // Bits per pixel, shared by the banks and every stream
    localparam int PIXEL_WIDTH = 18;

    typedef logic [PIXEL_WIDTH-1:0] pixel_t;

    ////////////////////////////////////////////////////////////////////////////
    // Stream payloads
    ////////////////////////////////////////////////////////////////////////////

    // Input beat in raster order
    typedef struct packed {
        logic   sof;    // first pixel of a frame
        pixel_t pixel;
    } in_beat_t;

    // Vertical 3x1 column for the convolution front end
    typedef struct packed {
        pixel_t top;    // two rows back
        pixel_t mid;    // previous row
        pixel_t bot;    // current row
    } column_t;

    ////////////////////////////////////////////////////////////////////////////
    // Row phase
    ////////////////////////////////////////////////////////////////////////////

    // Names the bank that holds the older of the two stored rows
    typedef logic bank_sel_t;

endpackage

// ==== hw/pixel_skid_buf.sv ====
`timescale 1ns/1ps

module pixel_skid_buf #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,

    // Producer side
    input  logic     up_valid,
    output logic     up_ready,
    input  payload_t up_data,

    // Consumer side
    output logic     down_valid,
    input  logic     down_ready,
    output payload_t down_data
);

    logic     full_q;
    payload_t slot_q;

    // Empty buffer is a plain pass-through
    assign up_ready   = !full_q;
    assign down_valid = full_q || up_valid;
    assign down_data  = full_q ? slot_q : up_data;

    ////////////////////////////////////////////////////////////////////////////
    // Slot occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (full_q) begin
            // Held item leaves once the consumer takes it
            if (down_ready) begin
                full_q <= 1'b0;
            end
        end else if (up_valid && !down_ready) begin
            full_q <= 1'b1;
        end
    end

    // Capture the refused item
    always_ff @(posedge clk) begin
        if (!full_q && up_valid && !down_ready) begin
            slot_q <= up_data;
        end
    end

endmodule

// ==== hw/raster_tracker.sv ====
`timescale 1ns/1ps

module raster_tracker
    import row_buffer_pkg::*;
#(
    parameter int  MAX_COLS = 1024,
    localparam int ADDR_W   = $clog2(MAX_COLS)
) (
    input  logic              clk,
    input  logic              rst,

    // Incoming pixel stream
    input  logic              in_valid,
    output logic              in_ready,
    input  in_beat_t          in_beat,
    input  logic [ADDR_W:0]   num_cols,

    // Tagged beat towards the window assembler
    output logic              out_valid,
    input  logic              out_ready,
    output pixel_t            out_pixel,
    output bank_sel_t         out_phase,
    output logic              out_primed,

    // Shared bank port control
    output logic              wr_en,
    output bank_sel_t         wr_bank,
    output logic [ADDR_W-1:0] addr
);

    logic [ADDR_W-1:0] col_q;
    logic [1:0]        row_q;
    bank_sel_t         phase_q;
    logic              out_valid_q;

    logic [ADDR_W-1:0] cur_col;
    logic [1:0]        cur_row;
    bank_sel_t         cur_phase;
    logic              accept;
    logic              last_col;

    assign in_ready  = !out_valid_q || out_ready;
    assign accept    = in_valid && in_ready;
    assign out_valid = out_valid_q;

    // Start of frame restarts the raster on its own beat
    assign cur_col   = in_beat.sof ? '0 : col_q;
    assign cur_row   = in_beat.sof ? 2'd0 : row_q;
    assign cur_phase = in_beat.sof ? 1'b0 : phase_q;
    assign last_col  = {1'b0, cur_col} == num_cols - 1'b1;

    // Older row is read out and replaced by the current one
    assign wr_en   = accept;
    assign wr_bank = cur_phase;
    assign addr    = cur_col;

    ////////////////////////////////////////////////////////////////////////////
    // Raster position
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            col_q   <= '0;
            row_q   <= 2'd0;
            phase_q <= 1'b0;
        end else if (accept) begin
            if (last_col) begin
                col_q   <= '0;
                phase_q <= ~cur_phase;
                // Saturates once the buffer is primed
                row_q   <= (cur_row == 2'd2) ? 2'd2 : cur_row + 2'd1;
            end else begin
                col_q   <= cur_col + 1'b1;
                phase_q <= cur_phase;
                row_q   <= cur_row;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
        end else if (accept) begin
            out_valid_q <= 1'b1;
        end else if (out_ready) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_pixel  <= in_beat.pixel;
            out_phase  <= cur_phase;
            out_primed <= cur_row == 2'd2;
        end
    end

endmodule

// ==== hw/row_bank_ram.sv ====
`timescale 1ns/1ps

module row_bank_ram
    import row_buffer_pkg::*;
#(
    parameter int  MAX_COLS = 1024,
    localparam int ADDR_W   = $clog2(MAX_COLS)
) (
    input  logic              clk,
    input  logic              wr_en,
    input  logic              rd_en,
    input  logic [ADDR_W-1:0] addr,
    input  pixel_t            wr_data,
    output pixel_t            rd_data
);

    // One stored image row
    pixel_t mem [0:MAX_COLS-1];

    ////////////////////////////////////////////////////////////////////////////
    // Read-first access
    ////////////////////////////////////////////////////////////////////////////

    // Old content comes out when read and write share a cycle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[addr];
        end
        if (wr_en) begin
            mem[addr] <= wr_data;
        end
    end

endmodule

// ==== hw/window_assembler.sv ====
`timescale 1ns/1ps

module window_assembler
    import row_buffer_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Tagged beat from the raster tracker
    input  logic      in_valid,
    output logic      in_ready,
    input  pixel_t    in_pixel,
    input  bank_sel_t in_phase,
    input  logic      in_primed,

    // Bank read data, valid one cycle after the tracker accepted the beat
    input  pixel_t    bank0_data,
    input  pixel_t    bank1_data,

    // Column stream
    output logic      out_valid,
    input  logic      out_ready,
    output column_t   out_col
);

    logic    out_valid_q;
    logic    take;
    column_t col_next;

    assign in_ready  = !out_valid_q || out_ready;
    assign take      = in_valid && in_ready;
    assign out_valid = out_valid_q;

    ////////////////////////////////////////////////////////////////////////////
    // Row ordering
    ////////////////////////////////////////////////////////////////////////////

    // Phase bank returned the row two back, the other bank the previous row
    always_comb begin
        col_next.top = in_phase ? bank1_data : bank0_data;
        col_next.mid = in_phase ? bank0_data : bank1_data;
        col_next.bot = in_pixel;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Column register
    ////////////////////////////////////////////////////////////////////////////

    // Beats from rows 0 and 1 are taken and dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
        end else if (take) begin
            out_valid_q <= in_primed;
        end else if (out_ready) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take && in_primed) begin
            out_col <= col_next;
        end
    end

endmodule

// ==== hw/row_buffer_top.sv ====
`timescale 1ns/1ps

module row_buffer_top
    import row_buffer_pkg::*;
#(
    parameter int  MAX_COLS = 1024,
    localparam int ADDR_W   = $clog2(MAX_COLS)
) (
    input  logic            clk,
    input  logic            rst,

    // Pixel input in raster order
    input  logic            in_valid,
    output logic            in_ready,
    input  in_beat_t        in_beat,

    // Column output
    output logic            col_valid,
    input  logic            col_ready,
    output column_t         col_data,

    // Frame width, stable within a frame
    input  logic [ADDR_W:0] num_cols
);

    // Input skid to tracker
    logic              skid_valid;
    logic              trk_in_ready;
    in_beat_t          skid_beat;

    // Tracker to assembler
    logic              trk_valid;
    logic              asm_in_ready;
    pixel_t            trk_pixel;
    bank_sel_t         trk_phase;
    logic              trk_primed;

    // Bank control and data
    logic              wr_en;
    bank_sel_t         wr_bank;
    logic [ADDR_W-1:0] addr;
    pixel_t            bank0_data;
    pixel_t            bank1_data;

    // Assembler to output skid
    logic              asm_valid;
    logic              asm_out_ready;
    column_t           asm_col;

    ////////////////////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////////////////////

    pixel_skid_buf #(.payload_t(in_beat_t)) in_skid (
        .clk        (clk),
        .rst        (rst),
        .up_valid   (in_valid),
        .up_ready   (in_ready),
        .up_data    (in_beat),
        .down_valid (skid_valid),
        .down_ready (trk_in_ready),
        .down_data  (skid_beat)
    );

    raster_tracker #(.MAX_COLS(MAX_COLS)) tracker (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (skid_valid),
        .in_ready   (trk_in_ready),
        .in_beat    (skid_beat),
        .num_cols   (num_cols),
        .out_valid  (trk_valid),
        .out_ready  (asm_in_ready),
        .out_pixel  (trk_pixel),
        .out_phase  (trk_phase),
        .out_primed (trk_primed),
        .wr_en      (wr_en),
        .wr_bank    (wr_bank),
        .addr       (addr)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Row banks
    ////////////////////////////////////////////////////////////////////////////

    // Every accepted beat reads both banks and writes the phase bank
    row_bank_ram #(.MAX_COLS(MAX_COLS)) bank_0 (
        .clk     (clk),
        .wr_en   (wr_en && wr_bank == 1'b0),
        .rd_en   (wr_en),
        .addr    (addr),
        .wr_data (skid_beat.pixel),
        .rd_data (bank0_data)
    );

    row_bank_ram #(.MAX_COLS(MAX_COLS)) bank_1 (
        .clk     (clk),
        .wr_en   (wr_en && wr_bank == 1'b1),
        .rd_en   (wr_en),
        .addr    (addr),
        .wr_data (skid_beat.pixel),
        .rd_data (bank1_data)
    );

    // Output side
    window_assembler assembler (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (trk_valid),
        .in_ready   (asm_in_ready),
        .in_pixel   (trk_pixel),
        .in_phase   (trk_phase),
        .in_primed  (trk_primed),
        .bank0_data (bank0_data),
        .bank1_data (bank1_data),
        .out_valid  (asm_valid),
        .out_ready  (asm_out_ready),
        .out_col    (asm_col)
    );

    pixel_skid_buf #(.payload_t(column_t)) out_skid (
        .clk        (clk),
        .rst        (rst),
        .up_valid   (asm_valid),
        .up_ready   (asm_out_ready),
        .up_data    (asm_col),
        .down_valid (col_valid),
        .down_ready (col_ready),
        .down_data  (col_data)
    );

endmodule

// ==== dv/row_buffer_chk.sv ====
`timescale 1ns/1ps

module row_buffer_chk
    import row_buffer_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    in_ready,
    input logic    col_valid,
    input logic    col_ready,
    input column_t col_data
);

    ////////////////////////////////////////////////////////////////////////
    // Output handshake
    ////////////////////////////////////////////////////////////////////////

    // Skid slot and column register are cleared by reset
    col_low_after_reset: assert property (
        @(posedge clk) rst |=> !col_valid
    ) else $error("col_valid is high in the cycle after reset");

    // A refused column stays on the port unchanged
    col_held_when_stalled: assert property (
        @(posedge clk) disable iff (rst)
        col_valid && !col_ready |=> col_valid && $stable(col_data)
    ) else $error("column dropped or changed while col_ready was low");

    ////////////////////////////////////////////////////////////////////////
    // Input stall recovery
    ////////////////////////////////////////////////////////////////////////

    // Consumer ready for two cycles drains the input skid slot
    in_stall_clears: assert property (
        @(posedge clk) disable iff (rst)
        col_ready && !in_ready && $past(col_ready) && !$past(in_ready) |=> in_ready
    ) else $error("in_ready stayed low although col_ready was high");

endmodule

// ==== dv/row_buffer_tb.sv ====
`timescale 1ns/1ps

module row_buffer_tb
    import row_buffer_pkg::*;
();

    localparam int MAX_COLS        = 16;
    localparam int ADDR_W          = $clog2(MAX_COLS);
    localparam int NC_W            = ADDR_W + 1;
    localparam int CLK_PERIOD      = 10;
    localparam int NUM_TESTS       = 9;
    localparam int DRAIN_CYCLES    = 8;
    localparam int WATCHDOG_MARGIN = 500;

    logic            clk;
    logic            rst;
    logic            in_valid;
    logic            in_ready;
    in_beat_t        in_beat;
    logic            col_valid;
    logic            col_ready;
    column_t         col_data;
    logic [NC_W-1:0] num_cols;

    // Test table with one frame per row
    string t_name  [NUM_TESTS];
    int    t_width [NUM_TESTS];
    int    t_rows  [NUM_TESTS];
    int    t_gap   [NUM_TESTS];
    int    t_bp    [NUM_TESTS];
    int    t_rst   [NUM_TESTS];
    int    t_exp   [NUM_TESTS];
    bit    table_loaded = 1'b0;

    // Reference model
    pixel_t      pix_q [$];
    column_t     exp_q [$];
    logic [15:0] lfsr_q;
    int          err_count;
    int          check_count;

    row_buffer_top #(.MAX_COLS(MAX_COLS)) row_buffer_top_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .col_valid (col_valid),
        .col_ready (col_ready),
        .col_data  (col_data),
        .num_cols  (num_cols)
    );

    bind row_buffer_top row_buffer_chk chk_i (
        .clk       (clk),
        .rst       (rst),
        .in_ready  (in_ready),
        .col_valid (col_valid),
        .col_ready (col_ready),
        .col_data  (col_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Random source
    ////////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // One LFSR step per bit taken
    task automatic next_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Table and model
    ////////////////////////////////////////////////////////////////////////

    task automatic add_test(input int idx, input string name, input int width,
                            input int rows, input int gap, input int bp,
                            input int pre_rst, input int exp_cols);
        t_name[idx]  = name;
        t_width[idx] = width;
        t_rows[idx]  = rows;
        t_gap[idx]   = gap;
        t_bp[idx]    = bp;
        t_rst[idx]   = pre_rst;
        t_exp[idx]   = exp_cols;
    endtask

    task automatic load_table();
        //       name               W  R  gap bp rst cols
        add_test(0, "plain_w8",      8, 6, 0, 0, 0, 32);
        add_test(1, "gaps_w5",       5, 7, 1, 0, 0, 25);
        add_test(2, "backpress_w12", 12, 5, 0, 1, 0, 36);
        add_test(3, "both_w16",      16, 6, 1, 1, 0, 64);
        add_test(4, "restart_w3",    3, 5, 1, 1, 0, 9);
        add_test(5, "prime_only_w7", 7, 2, 0, 1, 0, 0);
        add_test(6, "reset_w10",     10, 4, 1, 1, 1, 20);
        add_test(7, "single_col",    1, 6, 0, 1, 0, 4);
        add_test(8, "tall_w16",      16, 9, 1, 1, 0, 112);
    endtask

    // Frame pixels and the columns they must produce
    task automatic build_frame(input int t);
        logic [31:0] r;
        column_t     col;
        int          w;
        w = t_width[t];
        pix_q.delete();
        exp_q.delete();
        for (int i = 0; i < w * t_rows[t]; i++) begin
            next_bits(PIXEL_WIDTH, r);
            pix_q.push_back(r[PIXEL_WIDTH-1:0]);
        end
        for (int row = 2; row < t_rows[t]; row++) begin
            for (int c = 0; c < w; c++) begin
                col.top = pix_q[(row - 2) * w + c];
                col.mid = pix_q[(row - 1) * w + c];
                col.bot = pix_q[row * w + c];
                exp_q.push_back(col);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Drivers and checks
    ////////////////////////////////////////////////////////////////////////

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_beat   = '0;
        col_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_count++;
        if (col_valid !== 1'b0) begin
            $display("After reset col_valid is not low");
            err_count++;
        end
        if (in_ready !== 1'b1) begin
            $display("After reset in_ready is not high");
            err_count++;
        end
    endtask

    // Junk frame with the output blocked until the input side stalls
    task automatic fill_pipeline(input int t);
        logic [31:0] r;
        logic        in_fire;
        int          cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        num_cols  = NC_W'(t_width[t]);
        col_ready = 1'b0;
        next_bits(PIXEL_WIDTH, r);
        in_valid      = 1'b1;
        in_beat.sof   = 1'b1;
        in_beat.pixel = r[PIXEL_WIDTH-1:0];
        in_fire       = 1'b1;
        while (in_fire && cycles < 4 * MAX_COLS) begin
            @(negedge clk);
            in_fire = in_ready;
            @(posedge clk);
            #1;
            if (in_fire) begin
                next_bits(PIXEL_WIDTH, r);
                in_beat.sof   = 1'b0;
                in_beat.pixel = r[PIXEL_WIDTH-1:0];
            end
            cycles++;
        end
        check_count++;
        if (in_fire) begin
            $display("%s: input never stalled before the reset", t_name[t]);
            err_count++;
        end
    endtask

    task automatic drive_next(input int t, input int sent, input logic in_fire);
        logic [31:0] r;
        logic        go;
        int          npix;
        npix = t_width[t] * t_rows[t];
        if (t_bp[t] != 0) begin
            next_bits(1, r);
            col_ready = r[0];
        end else begin
            col_ready = 1'b1;
        end
        // Beat on the port is held until it is taken
        if (!in_valid || in_fire) begin
            go = 1'b1;
            if (t_gap[t] != 0) begin
                next_bits(1, r);
                go = r[0];
            end
            if (sent < npix && go) begin
                in_valid      = 1'b1;
                in_beat.sof   = (sent == 0);
                in_beat.pixel = pix_q[sent];
            end else begin
                in_valid    = 1'b0;
                in_beat.sof = 1'b0;
            end
        end
    endtask

    task automatic check_column(input int t, input int idx);
        column_t exp_col;
        check_count++;
        if (exp_q.size() == 0) begin
            $display("%s: column %0d arrived but none was expected", t_name[t], idx);
            err_count++;
        end else begin
            exp_col = exp_q.pop_front();
            if (col_data !== exp_col) begin
                $display("MISMATCH %s column %0d expected %h actual %h",
                         t_name[t], idx, exp_col, col_data);
                err_count++;
            end
        end
    endtask

    task automatic run_frame(input int t);
        int   npix;
        int   sent;
        int   got;
        int   extra;
        int   errs_at_start;
        logic in_fire;
        logic col_fire;
        npix          = t_width[t] * t_rows[t];
        sent          = 0;
        got           = 0;
        extra         = 0;
        errs_at_start = err_count;
        build_frame(t);
        @(posedge clk);
        #1;
        num_cols = NC_W'(t_width[t]);
        drive_next(t, sent, 1'b0);
        while (got < t_exp[t] || sent < npix) begin
            @(negedge clk);
            in_fire  = in_valid && in_ready;
            col_fire = col_valid && col_ready;
            if (col_fire) begin
                check_column(t, got);
                got++;
            end
            @(posedge clk);
            #1;
            if (in_fire) begin
                sent++;
            end
            drive_next(t, sent, in_fire);
        end
        // Nothing more may come out of this frame
        in_valid  = 1'b0;
        col_ready = 1'b1;
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            if (col_valid) begin
                extra++;
            end
        end
        check_count++;
        if (got + extra != t_exp[t]) begin
            $display("%s: expected %0d columns but received %0d",
                     t_name[t], t_exp[t], got + extra);
            err_count++;
        end
        $display("%s: %0d columns, %0d errors", t_name[t], got, err_count - errs_at_start);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////

    initial begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_beat     = '0;
        col_ready   = 1'b0;
        num_cols    = NC_W'(MAX_COLS);
        lfsr_q      = 16'd34426;
        err_count   = 0;
        check_count = 0;
        load_table();
        table_loaded = 1'b1;
        apply_reset();
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (t_rst[t] != 0) begin
                fill_pipeline(t);
                apply_reset();
            end
            run_frame(t);
        end
        $display("Tests %0d, checks %0d, errors %0d", NUM_TESTS, check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // 20 cycles per pixel over the whole table
    initial begin : watchdog
        int limit;
        wait (table_loaded);
        limit = WATCHDOG_MARGIN;
        for (int i = 0; i < NUM_TESTS; i++) begin
            limit += 20 * t_width[i] * t_rows[i];
        end
        repeat (limit) @(posedge clk);
        $display("Timeout: run did not finish within %0d clock cycles", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/row_buffer_pkg.sv
hw/pixel_skid_buf.sv
hw/raster_tracker.sv
hw/row_bank_ram.sv
hw/window_assembler.sv
hw/row_buffer_top.sv
dv/row_buffer_chk.sv
dv/row_buffer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module row_buffer_tb \
    -f vlog.f \
    -o row_buffer_sim

./obj_dir/row_buffer_sim 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
